//--- tests/core_cases.txt
# columns in hex: pc, instruction, branch_flag, branch_target, wb_en, wb_addr, wb_data
# target is checked only when the flag is 1, addr and data only when wb_en is 1
00400000 00000000 0 00000000 0 00 00000000
00400004 00000000 0 00000000 0 00 00000000
00400008 34018001 0 00000000 1 01 00008001
0040000c 2402fffe 0 00000000 1 02 fffffffe
00400010 3c031234 0 00000000 1 03 12340000
00400014 28440001 0 00000000 1 04 00000001
00400018 2c450001 0 00000000 1 05 00000000
0040001c 00233021 0 00000000 1 06 12348001
00400020 00c13822 0 00000000 1 07 12340000
00400024 00074100 0 00000000 1 08 23400000
00400028 00824807 0 00000000 1 09 ffffffff
0040002c 00885006 0 00000000 1 0a 11a00000
00400030 0041582a 0 00000000 1 0b 00000001
00400034 00230026 0 00000000 0 00 00000000
00400038 00016025 0 00000000 1 0c 00008001
0040003c 10e30004 1 00400050 0 00 00000000
00400040 14e3fffe 0 00000000 0 00 00000000
00400044 04510008 0 00000000 1 1f 0040004c
00400048 0450fffc 1 0040003c 1 1f 00400050
0040004c 03e00008 1 00400050 0 00 00000000
00400050 0c100040 1 00400100 1 1f 00400058
00400054 03e06809 1 00400058 1 0d 0040005c
a0000000 0bffffff 1 affffffc 0 00 00000000
0040005c 8c0e0000 0 00000000 0 00 00000000
00400060 1d800001 1 00400068 0 00 00000000
00400064 398effff 0 00000000 1 0e 00007ffe

//--- verilog.f
+incdir+tests
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/result.sv
logic/execute.sv
logic/decode.sv
logic/core_top.sv
tests/core_tb.sv

//--- Makefile
# Verilator build and run for the core testbench, run from the project root

.PHONY: run clean

run: obj_dir/Vcore_tb
	./obj_dir/Vcore_tb

obj_dir/Vcore_tb: verilog.f $(wildcard logic/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
		--top-module core_tb -f verilog.f

clean:
	rm -rf obj_dir

//--- tests/core_checks.svh
`ifndef CORE_CHECKS_SVH
`define CORE_CHECKS_SVH

task automatic check_word(input string name, input pipe_pkg::word_t exp,
                          input pipe_pkg::word_t got);
    if (got !== exp)
        stop_with_failure($sformatf("error at %0t ns: %s expected %h, got %h",
                                    $time, name, exp, got));
endtask

task automatic check_addr(input string name, input isa_pkg::reg_addr_t exp,
                          input isa_pkg::reg_addr_t got);
    if (got !== exp)
        stop_with_failure($sformatf("error at %0t ns: %s expected %0d, got %0d",
                                    $time, name, exp, got));
endtask

task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp)
        stop_with_failure($sformatf("error at %0t ns: %s expected %b, got %b",
                                    $time, name, exp, got));
endtask

`endif

//--- tests/core_tb.sv
`timescale 1ns/100ps

module core_tb;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_CYCLES = 2;    // writeback latency
    localparam int SLACK_CYCLES = 20;

    logic      clk = 1'b0;
    logic      rst_n;
    instr_t    ins;
    word_t     pc;
    logic      branch_flag;
    word_t     branch_target;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;

    // one entry per line of the case file
    word_t     case_pc[$];
    instr_t    case_ins[$];
    logic      exp_br_flag[$];
    word_t     exp_br_target[$];
    logic      exp_wb_en[$];
    reg_addr_t exp_wb_addr[$];
    word_t     exp_wb_data[$];

    int br_q[$];    // cases whose branch outputs are due next
    int wb_q[$];    // cases whose writeback is due next
    int cycles = 0;
    int limit  = 0;

    core_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .ins           (ins),
        .pc            (pc),
        .branch_flag   (branch_flag),
        .branch_target (branch_target),
        .wb_en         (wb_en),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data)
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    `include "core_checks.svh"

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [7];
        fd = $fopen("tests/core_cases.txt", "r");
        if (fd == 0)
            stop_with_failure("cannot open the case file tests/core_cases.txt");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.getc(0) == "#")
                continue;    // blank or comment line
            n = $sscanf(line, "%h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
            if (n != 7)
                stop_with_failure({"malformed line in the case file: ", line});
            case_pc.push_back(f[0]);
            case_ins.push_back(f[1]);
            exp_br_flag.push_back(f[2][0]);
            exp_br_target.push_back(f[3]);
            exp_wb_en.push_back(f[4][0]);
            exp_wb_addr.push_back(f[5][4:0]);
            exp_wb_data.push_back(f[6]);
        end
        $fclose(fd);
        if (case_pc.size() == 0)
            stop_with_failure("the case file holds no cases");
    endtask

    // branch outputs one cycle after a case, writeback one cycle later still
    task automatic score_pending();
        int i;
        if (wb_q.size() > 0) begin
            i = wb_q.pop_front();
            check_flag("wb_en", exp_wb_en[i], wb_en);
            if (exp_wb_en[i]) begin
                check_addr("wb_addr", exp_wb_addr[i], wb_addr);
                check_word("wb_data", exp_wb_data[i], wb_data);
            end
        end
        if (br_q.size() > 0) begin
            i = br_q.pop_front();
            check_flag("branch_flag", exp_br_flag[i], branch_flag);
            if (exp_br_flag[i])
                check_word("branch_target", exp_br_target[i], branch_target);
            wb_q.push_back(i);
        end
    endtask

    initial begin
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit)
            stop_with_failure("timeout: the run went past its cycle limit");
    end

    initial begin
        ins   = '0;
        pc    = '0;
        rst_n = 1'b0;
        load_cases();
        limit = RESET_CYCLES + case_pc.size() + DRAIN_CYCLES + SLACK_CYCLES;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_flag("wb_en", 1'b0, wb_en);
            check_flag("branch_flag", 1'b0, branch_flag);
        end
        rst_n = 1'b1;

        for (int n = 0; n < case_pc.size() + DRAIN_CYCLES; n++) begin
            @(negedge clk);
            score_pending();
            if (n < case_pc.size()) begin
                ins = case_ins[n];
                pc  = case_pc[n];
                br_q.push_back(n);
            end else begin
                ins = '0;    // nop while the pipe drains
                pc  = '0;
            end
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

//--- logic/core_top.sv
`timescale 1ns/100ps

module core_top (
    input  logic               clk,
    input  logic               rst_n,
    input  isa_pkg::instr_t    ins,
    input  pipe_pkg::word_t    pc,
    output logic               branch_flag,
    output pipe_pkg::word_t    branch_target,
    output logic               wb_en,
    output isa_pkg::reg_addr_t wb_addr,
    output pipe_pkg::word_t    wb_data
);
    import isa_pkg::*;
    import pipe_pkg::*;

    reg_addr_t rd1_addr;
    reg_addr_t rd2_addr;
    word_t     rd1_data;
    word_t     rd2_data;
    word_t     num1;
    word_t     num2;
    alu_op_e   alu_op;
    logic      wd_en;
    reg_addr_t wd_addr;
    word_t     link_address;
    logic      ex_wd_en;
    reg_addr_t ex_wd_addr;
    word_t     ex_result;

    decode decode_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .ins           (ins),
        .pc            (pc),
        .rd1_data      (rd1_data),
        .rd2_data      (rd2_data),
        .rd1_addr      (rd1_addr),
        .rd2_addr      (rd2_addr),
        .ex_wd_en      (ex_wd_en),
        .ex_wd_addr    (ex_wd_addr),
        .ex_result     (ex_result),
        .res_wd_en     (wb_en),        // writeback stage doubles as second forwarding path
        .res_wd_addr   (wb_addr),
        .res_data      (wb_data),
        .num1          (num1),
        .num2          (num2),
        .alu_op        (alu_op),
        .wd_en         (wd_en),
        .wd_addr       (wd_addr),
        .link_address  (link_address),
        .branch_flag   (branch_flag),
        .branch_target (branch_target)
    );

    execute execute_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .num1         (num1),
        .num2         (num2),
        .alu_op       (alu_op),
        .wd_en        (wd_en),
        .wd_addr      (wd_addr),
        .link_address (link_address),
        .ex_wd_en     (ex_wd_en),
        .ex_wd_addr   (ex_wd_addr),
        .ex_result    (ex_result),
        .res_wd_en    (wb_en),
        .res_wd_addr  (wb_addr),
        .res_data     (wb_data)
    );

    result result_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .res_wd_en   (wb_en),
        .res_wd_addr (wb_addr),
        .res_data    (wb_data),
        .rd1_addr    (rd1_addr),
        .rd2_addr    (rd2_addr),
        .rd1_data    (rd1_data),
        .rd2_data    (rd2_data)
    );

endmodule

//--- logic/decode.sv
`timescale 1ns/100ps

module decode (
    input  logic               clk,
    input  logic               rst_n,
    input  isa_pkg::instr_t    ins,
    input  pipe_pkg::word_t    pc,
    input  pipe_pkg::word_t    rd1_data,
    input  pipe_pkg::word_t    rd2_data,
    output isa_pkg::reg_addr_t rd1_addr,
    output isa_pkg::reg_addr_t rd2_addr,
    input  logic               ex_wd_en,
    input  isa_pkg::reg_addr_t ex_wd_addr,
    input  pipe_pkg::word_t    ex_result,
    input  logic               res_wd_en,
    input  isa_pkg::reg_addr_t res_wd_addr,
    input  pipe_pkg::word_t    res_data,
    output pipe_pkg::word_t    num1,
    output pipe_pkg::word_t    num2,
    output pipe_pkg::alu_op_e  alu_op,
    output logic               wd_en,
    output isa_pkg::reg_addr_t wd_addr,
    output pipe_pkg::word_t    link_address,
    output logic               branch_flag,
    output pipe_pkg::word_t    branch_target
);
    import isa_pkg::*;
    import pipe_pkg::*;

    typedef enum logic [3:0] {
        BR_NONE, BR_JUMP, BR_JREG, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ
    } br_kind_e;

    opcode_e    opcode;
    funct_e     funct;
    regimm_e    regimm;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [4:0] sa;
    word_t      pc_plus4;
    word_t      pc_plus8;
    word_t      br_offset;
    word_t      jump_target;
    word_t      imm_sext;
    word_t      imm_zext;
    logic       rd1_en;
    logic       rd2_en;
    logic       dst_en;
    logic       wen_d;
    reg_addr_t  dst_addr;
    alu_op_e    op_d;
    br_kind_e   br_kind;
    word_t      imm;
    word_t      op_a;
    word_t      op_b;
    logic       br_taken;
    word_t      br_tgt;

    assign opcode      = opcode_e'(ins[31:26]);
    assign funct       = funct_e'(ins[5:0]);
    assign regimm      = regimm_e'(ins[20:16]);
    assign rs          = ins[25:21];
    assign rt          = ins[20:16];
    assign rd          = ins[15:11];
    assign sa          = ins[10:6];
    assign pc_plus4    = pc + 32'd4;
    assign pc_plus8    = pc + 32'd8;                          // return address past the delay slot
    assign br_offset   = {{14{ins[15]}}, ins[15:0], 2'b00};
    assign jump_target = {pc_plus4[31:28], ins[25:0], 2'b00};
    assign imm_sext    = {{16{ins[15]}}, ins[15:0]};
    assign imm_zext    = {16'b0, ins[15:0]};
    assign rd1_addr    = rs;
    assign rd2_addr    = rt;
    assign wen_d       = dst_en && (dst_addr != '0);          // writes to $0 are dropped here

    always_comb begin
        rd1_en   = 1'b0;
        rd2_en   = 1'b0;
        dst_en   = 1'b0;
        dst_addr = rd;
        op_d     = ALU_NOP;
        br_kind  = BR_NONE;
        imm      = '0;
        case (opcode)
            OP_SPECIAL: begin
                rd1_en = 1'b1;
                rd2_en = 1'b1;
                dst_en = 1'b1;
                imm    = {27'b0, sa};                        // shift amount for fixed shifts
                case (funct)
                    FN_AND:          op_d = ALU_AND;
                    FN_OR:           op_d = ALU_OR;
                    FN_XOR:          op_d = ALU_XOR;
                    FN_NOR:          op_d = ALU_NOR;
                    FN_SLLV:         op_d = ALU_SLL;
                    FN_SRLV:         op_d = ALU_SRL;
                    FN_SRAV:         op_d = ALU_SRA;
                    FN_ADD, FN_ADDU: op_d = ALU_ADD;         // no overflow trap
                    FN_SUB, FN_SUBU: op_d = ALU_SUB;
                    FN_SLT:          op_d = ALU_SLT;
                    FN_SLTU:         op_d = ALU_SLTU;
                    FN_SLL: begin
                        rd1_en = 1'b0;
                        op_d   = ALU_SLL;
                    end
                    FN_SRL: begin
                        rd1_en = 1'b0;
                        op_d   = ALU_SRL;
                    end
                    FN_SRA: begin
                        rd1_en = 1'b0;
                        op_d   = ALU_SRA;
                    end
                    FN_JR: begin
                        rd2_en  = 1'b0;
                        dst_en  = 1'b0;
                        br_kind = BR_JREG;
                    end
                    FN_JALR: begin
                        rd2_en  = 1'b0;
                        op_d    = ALU_LINK;                  // link goes to rd
                        br_kind = BR_JREG;
                    end
                    default: begin
                        rd1_en = 1'b0;
                        rd2_en = 1'b0;
                        dst_en = 1'b0;
                    end
                endcase
            end
            OP_REGIMM: begin
                rd1_en   = 1'b1;
                dst_addr = LINK_REG;
                case (regimm)
                    RI_BLTZ: br_kind = BR_LTZ;
                    RI_BGEZ: br_kind = BR_GEZ;
                    RI_BLTZAL: begin
                        br_kind = BR_LTZ;
                        dst_en  = 1'b1;                      // link written taken or not
                        op_d    = ALU_LINK;
                    end
                    RI_BGEZAL: begin
                        br_kind = BR_GEZ;
                        dst_en  = 1'b1;
                        op_d    = ALU_LINK;
                    end
                    default: rd1_en = 1'b0;
                endcase
            end
            OP_J: br_kind = BR_JUMP;
            OP_JAL: begin
                br_kind  = BR_JUMP;
                dst_en   = 1'b1;
                dst_addr = LINK_REG;
                op_d     = ALU_LINK;
            end
            OP_BEQ: begin
                rd1_en  = 1'b1;
                rd2_en  = 1'b1;
                br_kind = BR_EQ;
            end
            OP_BNE: begin
                rd1_en  = 1'b1;
                rd2_en  = 1'b1;
                br_kind = BR_NE;
            end
            OP_BLEZ: begin
                rd1_en  = 1'b1;
                br_kind = BR_LEZ;
            end
            OP_BGTZ: begin
                rd1_en  = 1'b1;
                br_kind = BR_GTZ;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                rd1_en   = 1'b1;
                dst_en   = 1'b1;
                dst_addr = rt;
                imm      = imm_sext;
                op_d     = (opcode == OP_SLTI)  ? ALU_SLT  :
                           (opcode == OP_SLTIU) ? ALU_SLTU : ALU_ADD;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                rd1_en   = 1'b1;
                dst_en   = 1'b1;
                dst_addr = rt;
                imm      = imm_zext;
                op_d     = (opcode == OP_ANDI) ? ALU_AND :
                           (opcode == OP_ORI)  ? ALU_OR  : ALU_XOR;
            end
            OP_LUI: begin
                dst_en   = 1'b1;
                dst_addr = rt;
                imm      = {ins[15:0], 16'b0};
                op_d     = ALU_OR;                           // both operands carry the imm
            end
            default: ;
        endcase
    end

    function automatic word_t select_operand(input logic en, input reg_addr_t addr,
                                             input word_t rf_data);
        word_t val;
        if (!en)
            val = imm;
        else if (ex_wd_en && ex_wd_addr == addr)
            val = ex_result;                                 // youngest producer wins
        else if (res_wd_en && res_wd_addr == addr)
            val = res_data;
        else
            val = rf_data;
        return val;
    endfunction

    always_comb begin
        op_a = select_operand(rd1_en, rs, rd1_data);
        op_b = select_operand(rd2_en, rt, rd2_data);
    end

    always_comb begin
        br_taken = 1'b0;
        br_tgt   = pc_plus4 + br_offset;
        case (br_kind)
            BR_JUMP: begin
                br_taken = 1'b1;
                br_tgt   = jump_target;
            end
            BR_JREG: begin
                br_taken = 1'b1;
                br_tgt   = op_a;                             // forwarded rs
            end
            BR_EQ:   br_taken = (op_a == op_b);
            BR_NE:   br_taken = (op_a != op_b);
            BR_LEZ:  br_taken = op_a[31] || (op_a == '0);
            BR_GTZ:  br_taken = !op_a[31] && (op_a != '0);
            BR_LTZ:  br_taken = op_a[31];
            BR_GEZ:  br_taken = !op_a[31];
            default: br_taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_op      <= ALU_NOP;
            wd_en       <= 1'b0;
            branch_flag <= 1'b0;
        end else begin
            alu_op      <= op_d;
            wd_en       <= wen_d;
            branch_flag <= br_taken;
        end
    end

    always_ff @(posedge clk) begin
        num1          <= op_a;
        num2          <= op_b;
        wd_addr       <= dst_addr;
        link_address  <= pc_plus8;
        branch_target <= br_taken ? br_tgt : '0;
    end

    // only plain and linking control transfers may raise the flag
    a_branch_op: assert property (@(posedge clk) disable iff (!rst_n)
        branch_flag |-> alu_op inside {ALU_NOP, ALU_LINK});

endmodule

//--- logic/execute.sv
`timescale 1ns/100ps

module execute (
    input  logic               clk,
    input  logic               rst_n,
    input  pipe_pkg::word_t    num1,
    input  pipe_pkg::word_t    num2,
    input  pipe_pkg::alu_op_e  alu_op,
    input  logic               wd_en,
    input  isa_pkg::reg_addr_t wd_addr,
    input  pipe_pkg::word_t    link_address,
    output logic               ex_wd_en,
    output isa_pkg::reg_addr_t ex_wd_addr,
    output pipe_pkg::word_t    ex_result,
    output logic               res_wd_en,
    output isa_pkg::reg_addr_t res_wd_addr,
    output pipe_pkg::word_t    res_data
);
    import pipe_pkg::*;

    res_sel_e   sel;
    logic [4:0] shamt;
    word_t      logic_res;
    word_t      shift_res;
    word_t      arith_res;

    assign shamt = num1[4:0];   // sa or low bits of rs

    always_comb begin
        case (alu_op)
            ALU_AND, ALU_OR, ALU_XOR, ALU_NOR:    sel = RES_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:            sel = RES_SHIFT;
            ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU:  sel = RES_ARITH;
            ALU_LINK:                             sel = RES_JUMP_BRANCH;
            default:                              sel = RES_NOP;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_AND: logic_res = num1 & num2;
            ALU_OR:  logic_res = num1 | num2;
            ALU_XOR: logic_res = num1 ^ num2;
            default: logic_res = ~(num1 | num2);             // nor
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_SLL: shift_res = num2 << shamt;
            ALU_SRL: shift_res = num2 >> shamt;
            default: shift_res = word_t'($signed(num2) >>> shamt);
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_SUB:  arith_res = num1 - num2;
            ALU_SLT:  arith_res = {31'b0, $signed(num1) < $signed(num2)};
            ALU_SLTU: arith_res = {31'b0, num1 < num2};
            default:  arith_res = num1 + num2;
        endcase
    end

    always_comb begin
        case (sel)
            RES_LOGIC:       ex_result = logic_res;
            RES_SHIFT:       ex_result = shift_res;
            RES_ARITH:       ex_result = arith_res;
            RES_JUMP_BRANCH: ex_result = link_address;
            default:         ex_result = '0;
        endcase
    end

    assign ex_wd_en   = wd_en;     // first forwarding path
    assign ex_wd_addr = wd_addr;

    always_ff @(posedge clk) begin
        if (!rst_n)
            res_wd_en <= 1'b0;
        else
            res_wd_en <= wd_en;
    end

    always_ff @(posedge clk) begin
        res_wd_addr <= wd_addr;
        res_data    <= ex_result;
    end

    // pipe still empty in the first cycle after reset is released
    a_reset_no_write: assert property (@(posedge clk) $rose(rst_n) |=> !res_wd_en);

endmodule

//--- logic/result.sv
`timescale 1ns/100ps

module result (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               res_wd_en,
    input  isa_pkg::reg_addr_t res_wd_addr,
    input  pipe_pkg::word_t    res_data,
    input  isa_pkg::reg_addr_t rd1_addr,
    input  isa_pkg::reg_addr_t rd2_addr,
    output pipe_pkg::word_t    rd1_data,
    output pipe_pkg::word_t    rd2_data
);
    import pipe_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (res_wd_en) begin
            regs[res_wd_addr] <= res_data;
        end
    end

    // $0 is hardwired to zero
    assign rd1_data = (rd1_addr == '0) ? '0 : regs[rd1_addr];
    assign rd2_data = (rd2_addr == '0) ? '0 : regs[rd2_addr];

    // decode must strip every $0 destination before it reaches here
    a_no_zero_write: assert property (@(posedge clk) disable iff (!rst_n)
        res_wd_en |-> res_wd_addr != '0);

endmodule

//--- logic/pipe_pkg.sv
package pipe_pkg;

    typedef logic [31:0] word_t;   // data and pc

    // op carried from decode into execute
    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_LINK
    } alu_op_e;

    // which result group feeds the writeback word
    typedef enum logic [2:0] {
        RES_NOP,
        RES_LOGIC,
        RES_SHIFT,
        RES_ARITH,
        RES_JUMP_BRANCH
    } res_sel_e;

endpackage

//--- logic/isa_pkg.sv
package isa_pkg;

    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int REG_ADDR_W = 5;
    localparam int INSTR_W    = 32;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [INSTR_W-1:0]    instr_t;

    localparam reg_addr_t LINK_REG = 5'd31;   // return address for jal and linking branches

    // primary opcode, bits 31:26
    typedef enum logic [OPCODE_W-1:0] {
        OP_SPECIAL = 6'b000000,
        OP_REGIMM  = 6'b000001,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    // function field of SPECIAL, bits 5:0
    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    // rt field of REGIMM
    typedef enum logic [REG_ADDR_W-1:0] {
        RI_BLTZ   = 5'b00000,
        RI_BGEZ   = 5'b00001,
        RI_BLTZAL = 5'b10000,
        RI_BGEZAL = 5'b10001
    } regimm_e;

endpackage
